// ==== logic/ncpu_cmt_pkg.sv ====
// Shared widths and operation encodings; the body union is only meaningful for OP_MEM and OP_SYS
package ncpu_cmt_pkg;

   localparam int DW            = 64;                   // Data width
   localparam int PC_W          = 62;                   // Word-aligned PC
   localparam int PRF_AW        = 6;                    // Physical register address
   localparam int BPU_UPD_W     = 64;                   // Predictor update word
   localparam int BPU_UPD_TAKEN = BPU_UPD_W - 1;        // Predicted taken bit

   typedef enum logic [1:0] {
      OP_ALU  = 2'd0,
      OP_MEM  = 2'd1,
      OP_SYS  = 2'd2,
      OP_NONE = 2'd3
   } op_kind_e;

   typedef struct packed {
      logic       store;                                // Store, else load
      logic [1:0] size;                                 // Log2 of access bytes
      logic       sign;                                 // Sign-extend load data
      logic       pref;                                 // Prefetch hint, no unit access
      logic       rsvd;
   } op_mem_t;

   typedef struct packed {
      logic       trap;                                 // Raise a trap
      logic       fence;                                // Ordering fence
      logic [3:0] ridx;                                 // System register index
   } op_sys_t;

   typedef union packed {
      op_mem_t mem;
      op_sys_t sys;
   } op_body_u;

   typedef struct packed {
      op_kind_e kind;
      op_body_u body;
   } op_word_t;

   typedef enum logic [1:0] {
      FU_IDLE    = 2'd0,
      FU_REQ     = 2'd1,                                // fu_req high, waiting for ack
      FU_RELEASE = 2'd2                                 // fu_req low, waiting for ack to drop
   } fu_state_e;

endpackage

// ==== logic/cmt_lane.sv ====
// One retire lane; mask_in must be the firing of the lane below, or the enable for lane 0
module cmt_lane
#(
   parameter bit P_BARRIER_EN = 1'b1                    // Off for lane 0
)
(
   input  logic                   valid,
   input  ncpu_cmt_pkg::op_word_t op,
   input  logic                   fls,
   input  logic                   is_bcc,
   input  logic                   is_brel,
   input  logic                   is_breg,
   input  logic                   mask_in,
   input  logic                   flush,
   output logic                   fire,
   output logic                   mask_out,
   output logic                   long_req,
   output logic                   branch
);
   logic needs_fu;
   logic is_fence;
   logic barrier;
   logic mask;

   // The body word is read as a memory or a system op depending on kind
   always_comb
   begin
      needs_fu = 1'b0;
      is_fence = 1'b0;
      case (op.kind)
         ncpu_cmt_pkg::OP_MEM:
            needs_fu = ~op.body.mem.pref;               // Prefetch retires locally
         ncpu_cmt_pkg::OP_SYS:
         begin
            is_fence = op.body.sys.fence;
            // A bare fence is handled here, anything else goes out
            needs_fu = op.body.sys.trap | (|op.body.sys.ridx) | ~op.body.sys.fence;
         end
         default:
            needs_fu = 1'b0;
      endcase
   end

   assign branch   = is_bcc | is_brel | is_breg;
   assign long_req = valid & needs_fu;

   // Such a lane must wait until it reaches lane 0
   assign barrier  = P_BARRIER_EN & (needs_fu | is_fence | fls | branch);

   assign mask     = mask_in & ~barrier & ~flush;
   assign fire     = valid & mask;
   assign mask_out = fire;                              // Keeps retirement a prefix

endmodule

// ==== logic/cmt_long_op_ctrl.sv ====
// Lane-0 long operations; the unit must hold fu_rdata and fu_exc while fu_ack is high
module cmt_long_op_ctrl
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          long_req0,
   input  logic                          fire0,
   input  logic                          fls0,
   input  ncpu_cmt_pkg::op_word_t        op0,
   input  logic [ncpu_cmt_pkg::DW-1:0]   opera0,
   input  logic                          fu_ack,
   input  logic [ncpu_cmt_pkg::DW-1:0]   fu_rdata,
   input  logic                          fu_exc,
   output logic                          fu_req,
   output ncpu_cmt_pkg::op_word_t        fu_op,
   output logic [ncpu_cmt_pkg::DW-1:0]   fu_opera,
   output logic                          cmt_ce,
   output logic                          finish,
   output logic [ncpu_cmt_pkg::DW-1:0]   fu_result,
   output logic                          flush,
   output logic [ncpu_cmt_pkg::PC_W-1:0] flush_tgt
);
   ncpu_cmt_pkg::fu_state_e            state_q;
   ncpu_cmt_pkg::fu_state_e            state_d;
   logic                               start;
   logic                               ack_seen;
   logic                               exc_q;
   logic                               redir_q;
   logic [ncpu_cmt_pkg::PC_W-1:0]      redir_tgt_q;

   // No new request while a redirect discards the lane-0 operation
   assign start    = (state_q == ncpu_cmt_pkg::FU_IDLE) & long_req0 & ~redir_q & ~fu_ack;
   assign ack_seen = (state_q == ncpu_cmt_pkg::FU_REQ) & fu_ack;   // Rising edge of ack
   assign finish   = (state_q == ncpu_cmt_pkg::FU_RELEASE) & ~fu_ack;

   assign fu_req   = (state_q == ncpu_cmt_pkg::FU_REQ);
   assign fu_op    = op0;                               // Held by upstream while stalled
   assign fu_opera = opera0;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         ncpu_cmt_pkg::FU_IDLE:
            if (start)
               state_d = ncpu_cmt_pkg::FU_REQ;
         ncpu_cmt_pkg::FU_REQ:
            if (fu_ack)
               state_d = ncpu_cmt_pkg::FU_RELEASE;
         ncpu_cmt_pkg::FU_RELEASE:
            if (~fu_ack)
               state_d = ncpu_cmt_pkg::FU_IDLE;
         default:
            state_d = ncpu_cmt_pkg::FU_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state_q <= ncpu_cmt_pkg::FU_IDLE;
         redir_q <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         redir_q <= fire0 & fls0;                       // Flush itself blocks fire0 next cycle
      end
   end

   always_ff @(posedge clk)
   begin
      if (ack_seen)
      begin
         fu_result <= fu_rdata;
         exc_q     <= fu_exc;
      end
      if (fire0)
         redir_tgt_q <= opera0[ncpu_cmt_pkg::PC_W-1:0];
   end

   // Lane 0 may retire when it needs no unit, or once the unit is done
   assign cmt_ce = ~long_req0 | finish;

   // Redirect wins; exception target comes from the unit result
   assign flush     = redir_q | (finish & exc_q);
   assign flush_tgt = redir_q ? redir_tgt_q : fu_result[ncpu_cmt_pkg::PC_W-1:0];

endmodule

// ==== logic/cmt_retire.sv ====
// Retire count and lane-0 writebacks; only lane 0 updates the predictor or writes unit results
module cmt_retire
#(
   parameter int P_COMMIT_WIDTH = 2
)
(
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]    cmt_fire,
   input  logic                              finish,
   input  logic [ncpu_cmt_pkg::DW-1:0]       fu_result,
   input  logic                              flush,
   input  logic [ncpu_cmt_pkg::PRF_AW-1:0]   prd0,
   input  logic                              prd_we0,
   input  logic [ncpu_cmt_pkg::PC_W-1:0]     pc0,
   input  logic [ncpu_cmt_pkg::DW-1:0]       opera0,
   input  logic                              fls0,
   input  logic                              branch0,
   input  logic                              is_bcc0,
   input  logic                              is_brel0,
   input  logic                              is_breg0,
   input  logic [ncpu_cmt_pkg::BPU_UPD_W-1:0] bpu_upd0,
   output logic [P_COMMIT_WIDTH:0]           cmt_pop_size,
   output logic                              prf_we,
   output logic [ncpu_cmt_pkg::PRF_AW-1:0]   prf_waddr,
   output logic [ncpu_cmt_pkg::DW-1:0]       prf_wdata,
   output logic                              bpu_wb,
   output logic                              bpu_wb_is_bcc,
   output logic                              bpu_wb_is_brel,
   output logic                              bpu_wb_is_breg,
   output logic                              bpu_wb_taken,
   output logic [ncpu_cmt_pkg::PC_W-1:0]     bpu_wb_pc,
   output logic [ncpu_cmt_pkg::PC_W-1:0]     bpu_wb_npc_act,
   output logic [ncpu_cmt_pkg::BPU_UPD_W-1:0] bpu_wb_upd
);
   localparam int CW = 1 << P_COMMIT_WIDTH;

   // Number of lanes retired this cycle
   always_comb
   begin
      cmt_pop_size = '0;
      for (int i = 0; i < CW; i++)
         cmt_pop_size = cmt_pop_size + {{P_COMMIT_WIDTH{1'b0}}, cmt_fire[i]};
   end

   // Unit result is written only when the op really retires
   assign prf_we    = finish & ~flush & prd_we0;
   assign prf_waddr = prd0;
   assign prf_wdata = fu_result;

   assign bpu_wb         = cmt_fire[0] & branch0;
   assign bpu_wb_is_bcc  = is_bcc0;
   assign bpu_wb_is_brel = is_brel0;
   assign bpu_wb_is_breg = is_breg0;
   assign bpu_wb_taken   = bpu_upd0[ncpu_cmt_pkg::BPU_UPD_TAKEN] ^ fls0;  // Mispredict flips it
   assign bpu_wb_pc      = pc0;
   assign bpu_wb_npc_act = fls0 ? opera0[ncpu_cmt_pkg::PC_W-1:0]
                                : bpu_upd0[ncpu_cmt_pkg::PC_W-1:0];
   assign bpu_wb_upd     = bpu_upd0;

endmodule

// ==== logic/ncpu_cmt_top.sv ====
// Commit stage with 1<<P_COMMIT_WIDTH lanes; upstream must hold all lane inputs while cmt_ce is low
module ncpu_cmt_top
#(
   parameter int P_COMMIT_WIDTH = 2
)
(
   input  logic                                                   clk,
   input  logic                                                   rst,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                         cmt_valid,
   input  ncpu_cmt_pkg::op_word_t [(1<<P_COMMIT_WIDTH)-1:0]       cmt_op,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0][ncpu_cmt_pkg::PC_W-1:0] cmt_pc,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0][ncpu_cmt_pkg::DW-1:0]   cmt_opera,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0][ncpu_cmt_pkg::PRF_AW-1:0] cmt_prd,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                         cmt_prd_we,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                         cmt_fls,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                         cmt_is_bcc,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                         cmt_is_brel,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                         cmt_is_breg,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0][ncpu_cmt_pkg::BPU_UPD_W-1:0] cmt_bpu_upd,
   // Function unit, four-phase handshake
   output logic                                                   fu_req,
   output ncpu_cmt_pkg::op_word_t                                 fu_op,
   output logic [ncpu_cmt_pkg::DW-1:0]                            fu_opera,
   input  logic                                                   fu_ack,
   input  logic [ncpu_cmt_pkg::DW-1:0]                            fu_rdata,
   input  logic                                                   fu_exc,
   // Redirect
   output logic                                                   flush,
   output logic [ncpu_cmt_pkg::PC_W-1:0]                          flush_tgt,
   // To ROB
   output logic [(1<<P_COMMIT_WIDTH)-1:0]                         cmt_fire,
   output logic [P_COMMIT_WIDTH:0]                                cmt_pop_size,
   // To register file
   output logic                                                   prf_we,
   output logic [ncpu_cmt_pkg::PRF_AW-1:0]                        prf_waddr,
   output logic [ncpu_cmt_pkg::DW-1:0]                            prf_wdata,
   // To predictor
   output logic                                                   bpu_wb,
   output logic                                                   bpu_wb_is_bcc,
   output logic                                                   bpu_wb_is_brel,
   output logic                                                   bpu_wb_is_breg,
   output logic                                                   bpu_wb_taken,
   output logic [ncpu_cmt_pkg::PC_W-1:0]                          bpu_wb_pc,
   output logic [ncpu_cmt_pkg::PC_W-1:0]                          bpu_wb_npc_act,
   output logic [ncpu_cmt_pkg::BPU_UPD_W-1:0]                     bpu_wb_upd
);
   localparam int CW = 1 << P_COMMIT_WIDTH;

   logic                          cmt_ce;
   logic                          finish;
   logic [ncpu_cmt_pkg::DW-1:0]   fu_result;
   logic [CW:0]                   mask_chain;             // Bit i feeds lane i
   logic [CW-1:0]                 long_req;
   logic [CW-1:0]                 branch;

   assign mask_chain[0] = cmt_ce;

   cmt_long_op_ctrl u_ctrl
   (
      .clk       (clk),
      .rst       (rst),
      .long_req0 (long_req[0]),
      .fire0     (cmt_fire[0]),
      .fls0      (cmt_fls[0]),
      .op0       (cmt_op[0]),
      .opera0    (cmt_opera[0]),
      .fu_ack    (fu_ack),
      .fu_rdata  (fu_rdata),
      .fu_exc    (fu_exc),
      .fu_req    (fu_req),
      .fu_op     (fu_op),
      .fu_opera  (fu_opera),
      .cmt_ce    (cmt_ce),
      .finish    (finish),
      .fu_result (fu_result),
      .flush     (flush),
      .flush_tgt (flush_tgt)
   );

   for (genvar i = 0; i < CW; i++)
   begin : g_lane
      cmt_lane
      #(
         .P_BARRIER_EN (i != 0)                           // Lane 0 is never held back by itself
      )
      u_lane
      (
         .valid    (cmt_valid[i]),
         .op       (cmt_op[i]),
         .fls      (cmt_fls[i]),
         .is_bcc   (cmt_is_bcc[i]),
         .is_brel  (cmt_is_brel[i]),
         .is_breg  (cmt_is_breg[i]),
         .mask_in  (mask_chain[i]),
         .flush    ((i == 0) ? flush : 1'b0),
         .fire     (cmt_fire[i]),
         .mask_out (mask_chain[i+1]),
         .long_req (long_req[i]),
         .branch   (branch[i])
      );
   end

   cmt_retire
   #(
      .P_COMMIT_WIDTH (P_COMMIT_WIDTH)
   )
   u_retire
   (
      .cmt_fire       (cmt_fire),
      .finish         (finish),
      .fu_result      (fu_result),
      .flush          (flush),
      .prd0           (cmt_prd[0]),
      .prd_we0        (cmt_prd_we[0]),
      .pc0            (cmt_pc[0]),
      .opera0         (cmt_opera[0]),
      .fls0           (cmt_fls[0]),
      .branch0        (branch[0]),
      .is_bcc0        (cmt_is_bcc[0]),
      .is_brel0       (cmt_is_brel[0]),
      .is_breg0       (cmt_is_breg[0]),
      .bpu_upd0       (cmt_bpu_upd[0]),
      .cmt_pop_size   (cmt_pop_size),
      .prf_we         (prf_we),
      .prf_waddr      (prf_waddr),
      .prf_wdata      (prf_wdata),
      .bpu_wb         (bpu_wb),
      .bpu_wb_is_bcc  (bpu_wb_is_bcc),
      .bpu_wb_is_brel (bpu_wb_is_brel),
      .bpu_wb_is_breg (bpu_wb_is_breg),
      .bpu_wb_taken   (bpu_wb_taken),
      .bpu_wb_pc      (bpu_wb_pc),
      .bpu_wb_npc_act (bpu_wb_npc_act),
      .bpu_wb_upd     (bpu_wb_upd)
   );

endmodule

// ==== testbench/ncpu_cmt_chk.sv ====
// Bound to ncpu_cmt_top; assumes the unit holds fu_rdata and fu_exc while fu_ack is high
module ncpu_cmt_chk
#(
   parameter int P_COMMIT_WIDTH = 2
)
(
   input logic                                                   clk,
   input logic                                                   rst,
   input logic [(1<<P_COMMIT_WIDTH)-1:0]                         cmt_valid,
   input ncpu_cmt_pkg::op_word_t [(1<<P_COMMIT_WIDTH)-1:0]       cmt_op,
   input logic [(1<<P_COMMIT_WIDTH)-1:0][ncpu_cmt_pkg::PC_W-1:0] cmt_pc,
   input logic [(1<<P_COMMIT_WIDTH)-1:0][ncpu_cmt_pkg::DW-1:0]   cmt_opera,
   input logic [(1<<P_COMMIT_WIDTH)-1:0][ncpu_cmt_pkg::PRF_AW-1:0] cmt_prd,
   input logic [(1<<P_COMMIT_WIDTH)-1:0]                         cmt_prd_we,
   input logic [(1<<P_COMMIT_WIDTH)-1:0]                         cmt_fls,
   input logic [(1<<P_COMMIT_WIDTH)-1:0]                         cmt_is_bcc,
   input logic [(1<<P_COMMIT_WIDTH)-1:0]                         cmt_is_brel,
   input logic [(1<<P_COMMIT_WIDTH)-1:0]                         cmt_is_breg,
   input logic [(1<<P_COMMIT_WIDTH)-1:0][ncpu_cmt_pkg::BPU_UPD_W-1:0] cmt_bpu_upd,
   input logic                                                   fu_req,
   input ncpu_cmt_pkg::op_word_t                                 fu_op,
   input logic [ncpu_cmt_pkg::DW-1:0]                            fu_opera,
   input logic                                                   fu_ack,
   input logic [ncpu_cmt_pkg::DW-1:0]                            fu_rdata,
   input logic                                                   fu_exc,
   input logic                                                   flush,
   input logic [ncpu_cmt_pkg::PC_W-1:0]                          flush_tgt,
   input logic [(1<<P_COMMIT_WIDTH)-1:0]                         cmt_fire,
   input logic [P_COMMIT_WIDTH:0]                                cmt_pop_size,
   input logic                                                   prf_we,
   input logic [ncpu_cmt_pkg::PRF_AW-1:0]                        prf_waddr,
   input logic [ncpu_cmt_pkg::DW-1:0]                            prf_wdata,
   input logic                                                   bpu_wb,
   input logic                                                   bpu_wb_is_bcc,
   input logic                                                   bpu_wb_is_brel,
   input logic                                                   bpu_wb_is_breg,
   input logic                                                   bpu_wb_taken,
   input logic [ncpu_cmt_pkg::PC_W-1:0]                          bpu_wb_pc,
   input logic [ncpu_cmt_pkg::PC_W-1:0]                          bpu_wb_npc_act,
   input logic [ncpu_cmt_pkg::BPU_UPD_W-1:0]                     bpu_wb_upd
);
   localparam int CW = 1 << P_COMMIT_WIDTH;
   localparam int PW = ncpu_cmt_pkg::PC_W;

   int                          fail_cnt = 0;
   logic                        rel_q;                  // Ack seen, waiting for it to drop
   logic                        exc_cap;
   logic [ncpu_cmt_pkg::DW-1:0] data_cap;
   logic                        op_end;
   logic                        prefix_ok;
   logic                        br0;

   // Memory ops go out unless prefetch; system ops unless a bare fence
   function automatic logic needs_unit(ncpu_cmt_pkg::op_word_t op);
      logic bare_fence;
      bare_fence = op.body.sys.fence & ~op.body.sys.trap & (op.body.sys.ridx == 4'd0);
      if (op.kind == ncpu_cmt_pkg::OP_MEM)
         return ~op.body.mem.pref;
      if (op.kind == ncpu_cmt_pkg::OP_SYS)
         return ~bare_fence;
      return 1'b0;
   endfunction

   always_comb
   begin
      prefix_ok = 1'b1;
      for (int i = 1; i < CW; i++)
         if (cmt_fire[i] && (!cmt_fire[i-1] || needs_unit(cmt_op[i]) || cmt_fls[i]
             || cmt_is_bcc[i] || cmt_is_brel[i] || cmt_is_breg[i]
             || (cmt_op[i].kind == ncpu_cmt_pkg::OP_SYS && cmt_op[i].body.sys.fence)))
            prefix_ok = 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         rel_q <= 1'b0;
      else if (fu_req && fu_ack)
      begin
         rel_q    <= 1'b1;
         data_cap <= fu_rdata;
         exc_cap  <= fu_exc;
      end
      else if (!fu_ack)
         rel_q <= 1'b0;
   end

   assign op_end = rel_q & ~fu_ack;
   assign br0    = cmt_is_bcc[0] | cmt_is_brel[0] | cmt_is_breg[0];

   a_subset: assert property (@(posedge clk) disable iff (rst) (cmt_fire & ~cmt_valid) == '0)
      else begin fail_cnt++; $error("fire outside valid"); end
   a_prefix: assert property (@(posedge clk) disable iff (rst) prefix_ok)
      else begin fail_cnt++; $error("retire is not a prefix"); end
   a_count: assert property (@(posedge clk) disable iff (rst)
      cmt_pop_size == (P_COMMIT_WIDTH+1)'($countones(cmt_fire)))
      else begin fail_cnt++; $error("cmt_pop_size %h", cmt_pop_size); end
   a_redir: assert property (@(posedge clk) disable iff (rst) cmt_fire[0] && cmt_fls[0]
      |=> flush && flush_tgt == $past(cmt_opera[0][PW-1:0]))
      else begin fail_cnt++; $error("redirect flush_tgt %h", flush_tgt); end
   a_redir_once: assert property (@(posedge clk) disable iff (rst)
      flush && $past(cmt_fire[0] && cmt_fls[0]) |=> !flush || (op_end && exc_cap))
      else begin fail_cnt++; $error("flush longer than one cycle"); end
   a_reset: assert property (@(posedge clk) rst |=> !fu_req && !flush && !prf_we)
      else begin fail_cnt++; $error("outputs active after reset"); end
   a_req_rise: assert property (@(posedge clk) disable iff (rst)
      $rose(fu_req) |-> !$past(fu_ack) && $past(cmt_valid[0] && needs_unit(cmt_op[0])))
      else begin fail_cnt++; $error("fu_req rose illegally"); end
   a_req_fall: assert property (@(posedge clk) disable iff (rst) $fell(fu_req) |-> $past(fu_ack))
      else begin fail_cnt++; $error("fu_req fell before fu_ack"); end
   a_fu_bus: assert property (@(posedge clk) disable iff (rst) fu_req
      |-> fu_op == cmt_op[0] && fu_opera == cmt_opera[0])
      else begin fail_cnt++; $error("fu_opera %h", fu_opera); end
   a_stall: assert property (@(posedge clk) disable iff (rst) fu_req || fu_ack |-> cmt_fire == '0)
      else begin fail_cnt++; $error("lane fired during handshake"); end
   a_done: assert property (@(posedge clk) disable iff (rst) op_end && !exc_cap
      |-> cmt_fire[0] && prf_we == cmt_prd_we[0]
      && (!prf_we || (prf_wdata == data_cap && prf_waddr == cmt_prd[0])))
      else begin fail_cnt++; $error("long op end prf_wdata %h", prf_wdata); end
   a_exc: assert property (@(posedge clk) disable iff (rst) op_end && exc_cap
      |-> flush && flush_tgt == data_cap[PW-1:0] && cmt_fire == '0)
      else begin fail_cnt++; $error("exception flush_tgt %h", flush_tgt); end
   a_local: assert property (@(posedge clk) disable iff (rst) cmt_valid[0]
      && !needs_unit(cmt_op[0]) && !fu_req && !fu_ack && !flush |-> cmt_fire[0])
      else begin fail_cnt++; $error("local lane-0 op did not retire"); end
   a_bpu: assert property (@(posedge clk) disable iff (rst) bpu_wb == (cmt_fire[0] && br0))
      else begin fail_cnt++; $error("bpu_wb %h", bpu_wb); end
   a_bpu_val: assert property (@(posedge clk) disable iff (rst) bpu_wb
      |-> bpu_wb_taken == (cmt_bpu_upd[0][ncpu_cmt_pkg::BPU_UPD_W-1] ^ cmt_fls[0])
      && bpu_wb_npc_act == (cmt_fls[0] ? cmt_opera[0][PW-1:0] : cmt_bpu_upd[0][PW-1:0]))
      else begin fail_cnt++; $error("bpu_wb_npc_act %h", bpu_wb_npc_act); end
   a_bpu_fwd: assert property (@(posedge clk) disable iff (rst) bpu_wb
      |-> bpu_wb_pc == cmt_pc[0] && bpu_wb_upd == cmt_bpu_upd[0]
      && {bpu_wb_is_bcc, bpu_wb_is_brel, bpu_wb_is_breg}
         == {cmt_is_bcc[0], cmt_is_brel[0], cmt_is_breg[0]})
      else begin fail_cnt++; $error("bpu_wb_pc %h", bpu_wb_pc); end

endmodule

bind ncpu_cmt_top ncpu_cmt_chk #(.P_COMMIT_WIDTH(P_COMMIT_WIDTH)) u_chk (.*);

// ==== testbench/tb_ncpu_cmt.sv ====
// Four lanes; lane inputs are held until lane 0 retires, the unit answers in 1 to 4 cycles
module tb_ncpu_cmt;
   localparam int CWL         = 2;
   localparam int CW          = 1 << CWL;
   localparam int TEST_CYCLES = 140;                    // Sum of all test lengths

   logic                                        clk = 1'b0;
   logic                                        rst;
   logic [CW-1:0]                               cmt_valid;
   ncpu_cmt_pkg::op_word_t [CW-1:0]             cmt_op;
   logic [CW-1:0][ncpu_cmt_pkg::PC_W-1:0]       cmt_pc;
   logic [CW-1:0][ncpu_cmt_pkg::DW-1:0]         cmt_opera;
   logic [CW-1:0][ncpu_cmt_pkg::PRF_AW-1:0]     cmt_prd;
   logic [CW-1:0]                               cmt_prd_we, cmt_fls;
   logic [CW-1:0]                               cmt_is_bcc, cmt_is_brel, cmt_is_breg;
   logic [CW-1:0][ncpu_cmt_pkg::BPU_UPD_W-1:0]  cmt_bpu_upd;
   logic                                        fu_req, fu_ack, fu_exc;
   ncpu_cmt_pkg::op_word_t                      fu_op;
   logic [ncpu_cmt_pkg::DW-1:0]                 fu_opera, fu_rdata;
   logic                                        flush, prf_we, bpu_wb;
   logic [ncpu_cmt_pkg::PC_W-1:0]               flush_tgt, bpu_wb_pc, bpu_wb_npc_act;
   logic [CW-1:0]                               cmt_fire;
   logic [CWL:0]                                cmt_pop_size;
   logic [ncpu_cmt_pkg::PRF_AW-1:0]             prf_waddr;
   logic [ncpu_cmt_pkg::DW-1:0]                 prf_wdata;
   logic                                        bpu_wb_is_bcc, bpu_wb_is_brel, bpu_wb_is_breg;
   logic                                        bpu_wb_taken;
   logic [ncpu_cmt_pkg::BPU_UPD_W-1:0]          bpu_wb_upd;

   int   seed = 32'h9e5f22b2;
   logic exc_next;                                      // Exception for the next answer
   int   tests_run = 0;
   int   tests_failed = 0;
   int   fail_base;

   ncpu_cmt_top #(.P_COMMIT_WIDTH(CWL)) u_dut (.*);

   always #50 clk = ~clk;

   task automatic next_slot();
      @(posedge clk);
      #10;
   endtask

   task automatic clear_lanes();
      cmt_valid = '0;
      cmt_op = {CW{8'hc0}};                             // OP_NONE
      cmt_pc = '0;
      cmt_opera = '0;
      cmt_prd = '0;
      cmt_prd_we = '0;
      cmt_fls = '0;
      cmt_is_bcc = '0;
      cmt_is_brel = '0;
      cmt_is_breg = '0;
      cmt_bpu_upd = '0;
   endtask

   function automatic logic [63:0] rand64();
      return {$random(seed), $random(seed)};
   endfunction

   // Lane 0 retires, or its long op ends in an exception flush
   task automatic wait_lane0();
      do
         @(negedge clk);
      while (!(cmt_fire[0] || flush));
      next_slot();
      clear_lanes();
   endtask

   task automatic end_test(string name);
      int fails;
      repeat (3) next_slot();
      fails = u_dut.u_chk.fail_cnt - fail_base;
      tests_run++;
      if (fails != 0)
      begin
         tests_failed++;
         $display("%s: %0d assertion failures", name, fails);
      end
      else
         $display("%s: ok", name);
   endtask

   task automatic long_op(logic [7:0] op, logic we, logic exc);
      logic [63:0] w;
      w = rand64();
      cmt_valid[1:0] = 2'b11;
      cmt_op[0] = ncpu_cmt_pkg::op_word_t'(op);
      cmt_op[1] = ncpu_cmt_pkg::op_word_t'(8'h00); // ALU behind it
      cmt_prd[0] = w[5:0];
      cmt_prd_we[0] = we;
      cmt_opera[0] = rand64();
      exc_next = exc;
      wait_lane0();
   endtask

   // Function unit: answers after 1 to 4 cycles, releases after fu_req falls
   initial
   begin
      int r;
      fu_ack = 1'b0;
      fu_rdata = '0;
      fu_exc = 1'b0;
      forever
      begin
         @(posedge clk);
         if (fu_req && !fu_ack)
         begin
            r = $random(seed);
            repeat (r[1:0]) @(posedge clk);
            #10;
            fu_ack = 1'b1;
            fu_rdata = rand64();
            fu_exc = exc_next;
            do
               @(posedge clk);
            while (fu_req);
            #10;
            fu_ack = 1'b0;
         end
      end
   end

   initial
   begin
      #(TEST_CYCLES * 2 * 100);
      $display("Run timed out after %0d cycles", TEST_CYCLES * 2);
      $display("Testbench failed");
      $finish;
   end

   initial
   begin
      int r;
      logic [63:0] w;
      rst = 1'b1;
      exc_next = 1'b0;
      clear_lanes();
      repeat (4) next_slot();
      rst = 1'b0;

      fail_base = u_dut.u_chk.fail_cnt;
      repeat (40)
      begin
         next_slot();
         for (int i = 0; i < CW; i++)
         begin
            r = $random(seed);
            w = rand64();
            cmt_valid[i] = r[0];
            cmt_op[i] = ncpu_cmt_pkg::op_word_t'(r[15:8]);
            cmt_fls[i] = (i != 0) & r[1];
            cmt_is_bcc[i] = r[2] & r[3];
            cmt_is_brel[i] = r[2] & ~r[3];
            cmt_is_breg[i] = ~r[2] & r[5];
            cmt_pc[i] = w[61:0];
            cmt_opera[i] = rand64();
            cmt_bpu_upd[i] = rand64();
         end
         cmt_op[0].kind = r[4] ? ncpu_cmt_pkg::OP_ALU : ncpu_cmt_pkg::OP_NONE;
      end
      next_slot();
      clear_lanes();
      end_test("retire prefix");

      fail_base = u_dut.u_chk.fail_cnt;
      for (int k = 0; k < 2; k++)
      begin
         cmt_valid[1:0] = 2'b11;
         cmt_op[0] = ncpu_cmt_pkg::op_word_t'(8'h00);
         cmt_fls[0] = 1'b1;
         cmt_is_bcc[0] = 1'b1;
         cmt_opera[0] = rand64();
         cmt_bpu_upd[0] = rand64();
         next_slot();
         clear_lanes();
         repeat (2) next_slot();
      end
      end_test("redirect");

      fail_base = u_dut.u_chk.fail_cnt;
      cmt_valid[1:0] = 2'b11;
      cmt_op[0] = ncpu_cmt_pkg::op_word_t'(8'h42);      // Memory prefetch
      cmt_op[1] = ncpu_cmt_pkg::op_word_t'(8'h90);      // Bare fence, blocked in lane 1
      wait_lane0();
      cmt_valid[1:0] = 2'b11;
      cmt_op[0] = ncpu_cmt_pkg::op_word_t'(8'h90);
      cmt_op[1] = ncpu_cmt_pkg::op_word_t'(8'h00);
      wait_lane0();
      end_test("union decode");

      fail_base = u_dut.u_chk.fail_cnt;
      long_op(8'h4c, 1'b1, 1'b0);                       // Signed load
      long_op(8'h60, 1'b0, 1'b0);                       // Store
      long_op(8'h85, 1'b1, 1'b0);                       // System register
      long_op(8'ha0, 1'b0, 1'b1);                       // Trap with exception
      end_test("long operations");

      $display("%0d tests, %0d failed, %0d assertion failures",
               tests_run, tests_failed, u_dut.u_chk.fail_cnt);
      if (tests_failed == 0 && u_dut.u_chk.fail_cnt == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// ==== ncpu_cmt.f ====
logic/ncpu_cmt_pkg.sv
logic/cmt_lane.sv
logic/cmt_long_op_ctrl.sv
logic/cmt_retire.sv
logic/ncpu_cmt_top.sv
testbench/ncpu_cmt_chk.sv
testbench/tb_ncpu_cmt.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the commit stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_ncpu_cmt -f ncpu_cmt.f -o sim_ncpu_cmt
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_ncpu_cmt +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
   echo "Simulation ended without a result"
   exit 1
fi
exit 0
